// File: Makefile
# Verilator build and run for the eMesh transmit testbench

VERILATOR ?= verilator
TOP       ?= etx_tb
BUILD     ?= obj_dir
FILELIST  ?= tb.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG) || \
		{ echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/etx_tb_model.svh
// etx testbench model
// stimulus table, packet generator and expected link bytes

`ifndef ETX_TB_MODEL_SVH
`define ETX_TB_MODEL_SVH

// ##################################################
// stimulus table
// ##################################################

// channel codes, two bits per write in t_chan, write 0 in the low bits
// 0 write queue, 1 read request queue, 2 read response queue
localparam int n_tests = 5;

string       t_name [n_tests] = '{"single_write", "priority", "wait_gating",
                                  "full_flag", "back_to_back"};
int          t_n    [n_tests] = '{1, 9, 6, 8, 12};
logic [31:0] t_chan [n_tests] = '{32'h0000_0000, 32'h0002_4624, 32'h0000_0192,
                                  32'h0000_0000, 32'h0018_6186};
// wait levels as {rd_wait, wr_wait}: while loading, first drain, second drain
logic [1:0]  t_load [n_tests] = '{2'b00, 2'b11, 2'b11, 2'b11, 2'b11};
logic [1:0]  t_pha  [n_tests] = '{2'b00, 2'b00, 2'b01, 2'b00, 2'b00};
logic [1:0]  t_phb  [n_tests] = '{2'b00, 2'b00, 2'b00, 2'b00, 2'b00};
// check no gap between frames of the first drain
bit          t_gap  [n_tests] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
// check first byte latency
bit          t_lat  [n_tests] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

// ##################################################
// random payload
// ##################################################

// galois lfsr, one step per bit taken
function automatic logic [31:0] lfsr_step(input logic [31:0] st);
  logic lsb;
  lsb = st[0];
  st  = st >> 1;
  if (lsb) begin
    st = st ^ 32'h8020_0003;
  end
  return st;
endfunction

function automatic logic [emesh_pkg::packet_w-1:0] random_packet(inout logic [31:0] st);
  logic [emesh_pkg::packet_w-1:0] pkt;
  for (int i = 0; i < emesh_pkg::packet_w; i++) begin
    pkt[i] = st[0];
    st     = lfsr_step(st);
  end
  return pkt;
endfunction

// ##################################################
// expected link bytes
// ##################################################

// byte idx of the padded frame, msb first, pad bit is zero
function automatic logic [7:0] frame_byte(input logic [emesh_pkg::packet_w-1:0] pkt,
                                          input int idx);
  logic [103:0] fr;
  fr = {1'b0, pkt};
  return fr[103 - idx * 8 -: 8];
endfunction

`endif

// File: bench/etx_tb.sv
`timescale 1ns/1ps
// etx_tb
// table-driven testbench for the eMesh transmit path that checks frame
// contents, priority order, wait gating, full flag and frame spacing

module etx_tb;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic emwr_wr_en = 1'b0, emrq_wr_en = 1'b0, emrr_wr_en = 1'b0;
  logic [emesh_pkg::packet_w-1:0] emwr_wr_data = '0, emrq_wr_data = '0, emrr_wr_data = '0;
  logic tx_rd_wait = 1'b0, tx_wr_wait = 1'b0;
  logic emwr_full, emrq_full, emrr_full, tx_frame;
  logic [etx_cfg_pkg::byte_w-1:0] tx_byte;

  `include "etx_tb_model.svh"

  // per-channel model queues and expected link order
  logic [emesh_pkg::packet_w-1:0] chq [3][$];
  logic [emesh_pkg::packet_w-1:0] exp_q [$];
  logic [31:0] lfsr = 32'h86ae_a9c2;
  int cyc = 0, limit = 0, errors = 0, frames_done = 0, frames_target = 0;
  int byte_idx = 0, first_cyc = 0, wr_cyc = 0;
  bit gap_check = 1'b0, prev_frame = 1'b0, first_seen = 1'b0;

  etx_top u_etx_top (
    .clk(clk), .reset(reset),
    .emwr_wr_en(emwr_wr_en), .emwr_wr_data(emwr_wr_data), .emwr_full(emwr_full),
    .emrq_wr_en(emrq_wr_en), .emrq_wr_data(emrq_wr_data), .emrq_full(emrq_full),
    .emrr_wr_en(emrr_wr_en), .emrr_wr_data(emrr_wr_data), .emrr_full(emrr_full),
    .tx_rd_wait(tx_rd_wait), .tx_wr_wait(tx_wr_wait),
    .tx_byte(tx_byte), .tx_frame(tx_frame)
  );

  always #5 clk = ~clk;

  // cycle count and watchdog
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (limit != 0 && cyc > limit) begin
      $display("timeout: link stopped making progress after %0d cycles", cyc);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ##################################################
  // link receiver
  // ##################################################

  always @(posedge clk) begin
    if (reset) begin
      // registers are unknown until the first reset edge
      if (cyc != 0) begin
        assert (!tx_frame && !emwr_full && !emrq_full && !emrr_full) else begin
          $display("[FAIL] %0t frame or full flag active in reset", $time);
          errors++;
        end
      end
    end else begin
      if (tx_frame) begin
        if (byte_idx == 0 && !first_seen) begin
          first_seen = 1'b1;
          first_cyc  = cyc;
        end
        assert (exp_q.size() != 0) else begin
          $display("frame byte arrived with no packet expected at %0t", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          assert (tx_byte == frame_byte(exp_q[0], byte_idx)) else begin
            $display("[FAIL] %0t byte %0d got %h expected %h", $time, byte_idx,
                     tx_byte, frame_byte(exp_q[0], byte_idx));
            errors++;
          end
        end
        byte_idx++;
        if (byte_idx == etx_cfg_pkg::frame_bytes) begin
          if (exp_q.size() != 0) void'(exp_q.pop_front());
          frames_done++;
          byte_idx = 0;
        end
      end else begin
        assert (byte_idx == 0) else begin
          $display("frame ended after %0d bytes at %0t", byte_idx, $time);
          errors++;
        end
        byte_idx = 0;
      end
      // frames of one drain must follow each other directly
      if (gap_check && frames_done < frames_target) begin
        assert (tx_frame || !prev_frame) else begin
          $display("gap between frames at %0t", $time);
          errors++;
        end
      end
      prev_frame = tx_frame;
    end
  end

  // ##################################################
  // stimulus helpers
  // ##################################################

  task automatic drive_write(input int ch, input logic [emesh_pkg::packet_w-1:0] pkt);
    emwr_wr_en = (ch == 0);
    emrq_wr_en = (ch == 1);
    emrr_wr_en = (ch == 2);
    emwr_wr_data = pkt;
    emrq_wr_data = pkt;
    emrr_wr_data = pkt;
  endtask

  // applies the priority rule to the model queues and returns the packet count
  function automatic int predict_drain(input logic [1:0] waits);
    int n;
    int ch;
    n = 0;
    forever begin
      if (chq[2].size() != 0 && !waits[0]) ch = 2;
      else if (chq[1].size() != 0 && !waits[1]) ch = 1;
      else if (chq[0].size() != 0 && !waits[0]) ch = 0;
      else break;
      exp_q.push_back(chq[ch].pop_front());
      n++;
    end
    return n;
  endfunction

  task automatic run_drain(input logic [1:0] waits, input bit gap);
    @(negedge clk);
    frames_target = frames_target + predict_drain(waits);
    gap_check = gap;
    {tx_rd_wait, tx_wr_wait} = waits;
    while (frames_done < frames_target) @(negedge clk);
    gap_check = 1'b0;
  endtask

  // ##################################################
  // table loop
  // ##################################################

  initial begin
    int row_err;
    int ch;
    int cnt [3];
    limit = 16 + 200;
    for (int t = 0; t < n_tests; t++) begin
      limit += t_n[t] * (etx_cfg_pkg::frame_bytes + 2);
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int t = 0; t < n_tests; t++) begin
      row_err = errors;
      first_seen = 1'b0;
      cnt = '{0, 0, 0};
      {tx_rd_wait, tx_wr_wait} = t_load[t];
      for (int i = 0; i < t_n[t]; i++) begin
        @(negedge clk);
        // full flag after the previous write while the queues only fill
        if (i != 0 && t_load[t] == 2'b11) begin
          assert ((ch == 0 ? emwr_full : ch == 1 ? emrq_full : emrr_full)
                  == (cnt[ch] == etx_cfg_pkg::fifo_depth)) else begin
            $display("[FAIL] %0t full flag wrong after write %0d", $time, i);
            errors++;
          end
        end
        ch = int'(t_chan[t][2 * i +: 2]);
        chq[ch].push_back(random_packet(lfsr));
        drive_write(ch, chq[ch][$]);
        cnt[ch]++;
        wr_cyc = cyc;
      end
      @(negedge clk);
      emwr_wr_en = 1'b0;
      emrq_wr_en = 1'b0;
      emrr_wr_en = 1'b0;
      if (t_load[t] == 2'b11) begin
        assert ((ch == 0 ? emwr_full : ch == 1 ? emrq_full : emrr_full)
                == (cnt[ch] == etx_cfg_pkg::fifo_depth)) else begin
          $display("[FAIL] %0t full flag wrong after last write", $time);
          errors++;
        end
      end

      run_drain(t_pha[t], t_gap[t]);
      run_drain(t_phb[t], 1'b0);
      repeat (4) @(negedge clk);
      assert (exp_q.size() == 0 && byte_idx == 0 && frames_done == frames_target) else begin
        $display("[FAIL] %0t packets left over or extra frames", $time);
        errors++;
      end
      if (t_lat[t]) begin
        assert (first_cyc - wr_cyc == 3) else begin
          $display("[FAIL] %0t first byte after %0d cycles, expected 3", $time,
                   first_cyc - wr_cyc);
          errors++;
        end
      end
      $display("test %s done: %0d frames, %0d errors", t_name[t], t_n[t], errors - row_err);
    end

    $display("tests %0d, frames %0d, errors %0d", n_tests, frames_done, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+bench
verilog/emesh_pkg.sv
verilog/etx_cfg_pkg.sv
verilog/etx_fifo.sv
verilog/etx_arbiter.sv
verilog/etx_protocol.sv
verilog/etx_top.sv
bench/etx_tb.sv

// File: verilog/emesh_pkg.sv
// emesh packet format
// width of one eMesh transaction and where each field sits in the
// packed 103-bit vector

package emesh_pkg;

  // ##################################################
  // packet width
  // ##################################################

  // one transaction, write bit down to data word
  localparam int packet_w = 103;

  // ##################################################
  // field positions, lsb and width
  // ##################################################

  // write flag, single bit on top
  localparam int write_bit = 102;

  // transfer size code
  localparam int datamode_lsb = 100;
  localparam int datamode_w   = 2;

  // control mode nibble
  localparam int ctrlmode_lsb = 96;
  localparam int ctrlmode_w   = 4;

  // destination address
  localparam int dstaddr_lsb = 64;
  localparam int dstaddr_w   = 32;

  // source address, return address on reads
  localparam int srcaddr_lsb = 32;
  localparam int srcaddr_w   = 32;

  // data word
  localparam int data_lsb = 0;
  localparam int data_w   = 32;

endpackage

// File: verilog/etx_arbiter.sv
`timescale 1ns/1ps
// etx_arbiter
// fixed-priority pick between the three transmit queues,
// read responses first, then read requests, then writes

module etx_arbiter (
  input  logic                               clk,
  input  logic                               reset,
  // write queue
  input  logic [emesh_pkg::packet_w-1:0]     emwr_rd_data,
  input  logic                               emwr_empty,
  output logic                               emwr_rd_en,
  // read request queue
  input  logic [emesh_pkg::packet_w-1:0]     emrq_rd_data,
  input  logic                               emrq_empty,
  output logic                               emrq_rd_en,
  // read response queue
  input  logic [emesh_pkg::packet_w-1:0]     emrr_rd_data,
  input  logic                               emrr_empty,
  output logic                               emrr_rd_en,
  // link flow control and protocol ack
  input  logic                               tx_rd_wait,
  input  logic                               tx_wr_wait,
  input  logic                               ack,
  // packet out to the protocol block
  output logic                               access,
  output logic                               write,
  output logic [emesh_pkg::datamode_w-1:0]   datamode,
  output logic [emesh_pkg::ctrlmode_w-1:0]   ctrlmode,
  output logic [emesh_pkg::dstaddr_w-1:0]    dstaddr,
  output logic [emesh_pkg::srcaddr_w-1:0]    srcaddr,
  output logic [emesh_pkg::data_w-1:0]       data
);

  logic                           ready;
  logic [emesh_pkg::packet_w-1:0] fifo_data;
  logic                           rr_ready;
  logic                           rq_ready;
  logic                           wr_ready;
  logic                           pop_ok;

  // ##################################################
  // eligibility in priority order
  // ##################################################

  // responses and writes both wait on write-wait
  assign rr_ready = ~emrr_empty & ~tx_wr_wait;
  assign rq_ready = ~emrq_empty & ~tx_rd_wait & ~rr_ready;
  assign wr_ready = ~emwr_empty & ~tx_wr_wait & ~rr_ready & ~rq_ready;

  // pop when holding nothing, or when the current packet is done
  assign pop_ok     = ~ready | ack;
  assign emrr_rd_en = rr_ready & pop_ok;
  assign emrq_rd_en = rq_ready & pop_ok;
  assign emwr_rd_en = wr_ready & pop_ok;

  // ##################################################
  // holding register
  // ##################################################

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else if (emrr_rd_en | emrq_rd_en | emwr_rd_en) begin
      ready <= 1'b1;
    end else if (ack) begin
      ready <= 1'b0;
    end
  end

  // payload follows whichever queue was popped
  always_ff @(posedge clk) begin
    if (emrr_rd_en) begin
      fifo_data <= emrr_rd_data;
    end else if (emrq_rd_en) begin
      fifo_data <= emrq_rd_data;
    end else if (emwr_rd_en) begin
      fifo_data <= emwr_rd_data;
    end
  end

  // split into eMesh fields
  assign access   = ready;
  assign write    = fifo_data[emesh_pkg::write_bit];
  assign datamode = fifo_data[emesh_pkg::datamode_lsb +: emesh_pkg::datamode_w];
  assign ctrlmode = fifo_data[emesh_pkg::ctrlmode_lsb +: emesh_pkg::ctrlmode_w];
  assign dstaddr  = fifo_data[emesh_pkg::dstaddr_lsb +: emesh_pkg::dstaddr_w];
  assign srcaddr  = fifo_data[emesh_pkg::srcaddr_lsb +: emesh_pkg::srcaddr_w];
  assign data     = fifo_data[emesh_pkg::data_lsb +: emesh_pkg::data_w];

  // one queue popped at a time
  a_one_pop: assert property (
    @(posedge clk) disable iff (reset) $onehot0({emwr_rd_en, emrq_rd_en, emrr_rd_en})
  ) else $error("etx_arbiter: more than one rd_en");

endmodule

// File: verilog/etx_cfg_pkg.sv
// transmit path configuration
// queue sizing and byte framing of the outgoing link

package etx_cfg_pkg;

  // ##################################################
  // queues
  // ##################################################

  // entries per queue, power of two so pointers wrap on their own
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = 3;

  // ##################################################
  // link framing
  // ##################################################

  // link width
  localparam int byte_w      = 8;
  // 103-bit packet plus one leading pad bit
  localparam int frame_bytes = 13;
  localparam int frame_w     = frame_bytes * byte_w;
  // counts 0 .. frame_bytes-1
  localparam int byte_cnt_w  = 4;

endpackage

// File: verilog/etx_fifo.sv
`timescale 1ns/1ps
// etx_fifo
// synchronous first-word-fall-through queue for eMesh packets,
// head entry shows on rd_data whenever empty is low

module etx_fifo (
  input  logic                           clk,
  input  logic                           reset,
  // write side
  input  logic                           wr_en,
  input  logic [emesh_pkg::packet_w-1:0] wr_data,
  // read side
  input  logic                           rd_en,
  output logic [emesh_pkg::packet_w-1:0] rd_data,
  output logic                           empty,
  output logic                           full
);

  // ##################################################
  // storage and pointers
  // ##################################################

  logic [emesh_pkg::packet_w-1:0] mem [etx_cfg_pkg::fifo_depth];
  logic [etx_cfg_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [etx_cfg_pkg::fifo_ptr_w-1:0] rd_ptr;
  // one bit wider than the pointers, holds 0 .. depth
  logic [etx_cfg_pkg::fifo_ptr_w:0]   count;

  // entry array, payload only
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // occupancy, simultaneous push and pop leaves it alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ##################################################
  // status and head
  // ##################################################

  // head entry falls through, no read latency
  assign rd_data = mem[rd_ptr];
  assign empty   = (count == '0);
  assign full    = (count == (etx_cfg_pkg::fifo_ptr_w + 1)'(etx_cfg_pkg::fifo_depth));

  // writer must respect full, reader must respect empty
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (reset) wr_en |-> !full
  ) else $error("etx_fifo: write while full");

  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (reset) rd_en |-> !empty
  ) else $error("etx_fifo: pop while empty");

endmodule

// File: verilog/etx_protocol.sv
`timescale 1ns/1ps
// etx_protocol
// sends one eMesh packet as a padded frame, one byte per clock,
// msb first, and acks on the last byte

module etx_protocol (
  input  logic                               clk,
  input  logic                               reset,
  // packet from the arbiter
  input  logic                               access,
  input  logic                               write,
  input  logic [emesh_pkg::datamode_w-1:0]   datamode,
  input  logic [emesh_pkg::ctrlmode_w-1:0]   ctrlmode,
  input  logic [emesh_pkg::dstaddr_w-1:0]    dstaddr,
  input  logic [emesh_pkg::srcaddr_w-1:0]    srcaddr,
  input  logic [emesh_pkg::data_w-1:0]       data,
  // back to the arbiter
  output logic                               ack,
  // link
  output logic [etx_cfg_pkg::byte_w-1:0]     tx_byte,
  output logic                               tx_frame
);

  logic [emesh_pkg::packet_w-1:0]       pkt;
  logic [etx_cfg_pkg::frame_w-1:0]      pkt_pad;
  logic [etx_cfg_pkg::frame_w-1:0]      shreg;
  logic [etx_cfg_pkg::byte_cnt_w-1:0]   count;
  logic                                 busy;
  logic                                 first;
  logic                                 start;
  logic                                 last;

  // ##################################################
  // frame assembly
  // ##################################################

  // fields back into the packed packet
  assign pkt = {write, datamode, ctrlmode, dstaddr, srcaddr, data};

  // leading zero pad up to a whole number of bytes
  assign pkt_pad = {{(etx_cfg_pkg::frame_w - emesh_pkg::packet_w){1'b0}}, pkt};

  // ##################################################
  // sequencing
  // ##################################################

  // first-byte slot, taken only if a packet is on offer
  // after ack the slot may find access low, frame then ends there
  assign start = first & access;

  // last byte of the frame
  assign last = busy & (count == etx_cfg_pkg::byte_cnt_w'(etx_cfg_pkg::frame_bytes - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      first <= 1'b0;
      count <= '0;
    end else if (start) begin
      // byte 0 goes out now, byte 1 next
      busy  <= 1'b1;
      first <= 1'b0;
      count <= etx_cfg_pkg::byte_cnt_w'(1);
    end else if (last) begin
      // offer a slot straight away, back to back frames
      busy  <= 1'b0;
      first <= 1'b1;
      count <= '0;
    end else if (busy) begin
      count <= count + 1'b1;
    end else if (first) begin
      // nothing came after the ack
      first <= 1'b0;
    end else if (access) begin
      // idle, latch cycle before the first byte
      first <= 1'b1;
    end
  end

  // remaining bytes, top byte is the one on the link
  always_ff @(posedge clk) begin
    if (start) begin
      shreg <= pkt_pad << etx_cfg_pkg::byte_w;
    end else if (busy) begin
      shreg <= shreg << etx_cfg_pkg::byte_w;
    end
  end

  // ##################################################
  // link outputs
  // ##################################################

  assign tx_frame = busy | start;
  assign ack      = last;

  // byte 0 straight from the held fields, the rest from the shifter
  always_comb begin
    if (start) begin
      tx_byte = pkt_pad[etx_cfg_pkg::frame_w-1 -: etx_cfg_pkg::byte_w];
    end else if (busy) begin
      tx_byte = shreg[etx_cfg_pkg::frame_w-1 -: etx_cfg_pkg::byte_w];
    end else begin
      tx_byte = '0;
    end
  end

  // ack closes a frame that has been on the link for its full length
  a_ack_in_frame: assert property (
    @(posedge clk) disable iff (reset)
      ack |-> tx_frame && $past(tx_frame, etx_cfg_pkg::frame_bytes - 1)
  ) else $error("etx_protocol: ack outside a full frame");

endmodule

// File: verilog/etx_top.sv
`timescale 1ns/1ps
// etx_top
// transmit side of the eMesh link, three packet queues feeding a
// priority arbiter and the byte-wide link framer

module etx_top (
  input  logic                           clk,
  input  logic                           reset,
  // write queue fill side
  input  logic                           emwr_wr_en,
  input  logic [emesh_pkg::packet_w-1:0] emwr_wr_data,
  output logic                           emwr_full,
  // read request queue fill side
  input  logic                           emrq_wr_en,
  input  logic [emesh_pkg::packet_w-1:0] emrq_wr_data,
  output logic                           emrq_full,
  // read response queue fill side
  input  logic                           emrr_wr_en,
  input  logic [emesh_pkg::packet_w-1:0] emrr_wr_data,
  output logic                           emrr_full,
  // link flow control
  input  logic                           tx_rd_wait,
  input  logic                           tx_wr_wait,
  // link
  output logic [etx_cfg_pkg::byte_w-1:0] tx_byte,
  output logic                           tx_frame
);

  // queue read sides
  logic [emesh_pkg::packet_w-1:0] emwr_rd_data;
  logic [emesh_pkg::packet_w-1:0] emrq_rd_data;
  logic [emesh_pkg::packet_w-1:0] emrr_rd_data;
  logic emwr_empty, emrq_empty, emrr_empty;
  logic emwr_rd_en, emrq_rd_en, emrr_rd_en;

  // arbiter to protocol
  logic                             access;
  logic                             write;
  logic [emesh_pkg::datamode_w-1:0] datamode;
  logic [emesh_pkg::ctrlmode_w-1:0] ctrlmode;
  logic [emesh_pkg::dstaddr_w-1:0]  dstaddr;
  logic [emesh_pkg::srcaddr_w-1:0]  srcaddr;
  logic [emesh_pkg::data_w-1:0]     data;
  logic                             ack;

  // ##################################################
  // queues
  // ##################################################

  etx_fifo u_emwr_fifo (
    .clk(clk), .reset(reset), .wr_en(emwr_wr_en), .wr_data(emwr_wr_data),
    .rd_en(emwr_rd_en), .rd_data(emwr_rd_data), .empty(emwr_empty), .full(emwr_full)
  );

  etx_fifo u_emrq_fifo (
    .clk(clk), .reset(reset), .wr_en(emrq_wr_en), .wr_data(emrq_wr_data),
    .rd_en(emrq_rd_en), .rd_data(emrq_rd_data), .empty(emrq_empty), .full(emrq_full)
  );

  etx_fifo u_emrr_fifo (
    .clk(clk), .reset(reset), .wr_en(emrr_wr_en), .wr_data(emrr_wr_data),
    .rd_en(emrr_rd_en), .rd_data(emrr_rd_data), .empty(emrr_empty), .full(emrr_full)
  );

  // ##################################################
  // arbiter and link framer
  // ##################################################

  etx_arbiter u_etx_arbiter (
    .clk(clk), .reset(reset),
    .emwr_rd_data(emwr_rd_data), .emwr_empty(emwr_empty), .emwr_rd_en(emwr_rd_en),
    .emrq_rd_data(emrq_rd_data), .emrq_empty(emrq_empty), .emrq_rd_en(emrq_rd_en),
    .emrr_rd_data(emrr_rd_data), .emrr_empty(emrr_empty), .emrr_rd_en(emrr_rd_en),
    .tx_rd_wait(tx_rd_wait), .tx_wr_wait(tx_wr_wait), .ack(ack),
    .access(access), .write(write), .datamode(datamode), .ctrlmode(ctrlmode),
    .dstaddr(dstaddr), .srcaddr(srcaddr), .data(data)
  );

  etx_protocol u_etx_protocol (
    .clk(clk), .reset(reset),
    .access(access), .write(write), .datamode(datamode), .ctrlmode(ctrlmode),
    .dstaddr(dstaddr), .srcaddr(srcaddr), .data(data),
    .ack(ack), .tx_byte(tx_byte), .tx_frame(tx_frame)
  );

endmodule
